//--- logic/core_pkg.sv
`default_nettype none

package core_pkg;

  localparam int XLEN        = 32;
  localparam int IMEM_AWIDTH = 10;
  localparam int DMEM_AWIDTH = 10;

  typedef logic [XLEN-1:0]        word_t;
  typedef logic [4:0]             reg_addr_t;
  typedef logic [IMEM_AWIDTH-1:0] imem_addr_t;
  typedef logic [DMEM_AWIDTH-1:0] dmem_addr_t;

  localparam word_t       RESET_PC   = 32'h0000_0000;
  localparam logic [11:0] CSR_TOHOST = 12'h51E;

  // RV32I major opcodes
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // ALU function is {inst[30], funct3}
  localparam logic [3:0] ALU_ADD  = 4'b0000;
  localparam logic [3:0] ALU_SUB  = 4'b1000;
  localparam logic [3:0] ALU_SLL  = 4'b0001;
  localparam logic [3:0] ALU_SLT  = 4'b0010;
  localparam logic [3:0] ALU_SLTU = 4'b0011;
  localparam logic [3:0] ALU_XOR  = 4'b0100;
  localparam logic [3:0] ALU_SRL  = 4'b0101;
  localparam logic [3:0] ALU_SRA  = 4'b1101;
  localparam logic [3:0] ALU_OR   = 4'b0110;
  localparam logic [3:0] ALU_AND  = 4'b0111;

  // Operand selects
  localparam logic [1:0] SRC_A_RS1  = 2'd0;
  localparam logic [1:0] SRC_A_PC   = 2'd1;
  localparam logic [1:0] SRC_A_ZERO = 2'd2;
  localparam logic [1:0] SRC_B_RS2  = 2'd0;
  localparam logic [1:0] SRC_B_IMM  = 2'd1;
  localparam logic [1:0] SRC_B_FOUR = 2'd2;

  localparam logic WB_ALU = 1'b0;
  localparam logic WB_MEM = 1'b1;

  typedef struct packed {
    logic [3:0] alu_func;
    logic [1:0] alu_src_a;
    logic [1:0] alu_src_b;
    logic       reg_we;
    logic       mem_we;
    logic       mem_rd;
    logic       wb_sel;
    logic       csr_we;
    logic       csr_imm;    // Take zimm instead of rs1
    reg_addr_t  rd;
  } ex_ctrl_t;

  typedef struct packed {
    ex_ctrl_t ctrl;
    word_t    pc;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    imm;
  } id_ex_t;

  typedef struct packed {
    logic      reg_we;
    reg_addr_t rd;
    logic      wb_sel;
    word_t     result;
  } ex_wb_t;

endpackage

`default_nettype wire

//--- logic/sync_ram_dp.sv
`timescale 1ns/1ps
`default_nettype none

module sync_ram_dp #(
  parameter int AWIDTH = 10
) (
  input  wire logic              clk,

  input  wire logic              we_a,
  input  wire logic [AWIDTH-1:0] addr_a,
  input  core_pkg::word_t        wdata_a,
  output core_pkg::word_t        rdata_a,

  input  wire logic              we_b,
  input  wire logic [AWIDTH-1:0] addr_b,
  input  core_pkg::word_t        wdata_b,
  output core_pkg::word_t        rdata_b
);

  core_pkg::word_t mem [2**AWIDTH];

  // Read returns old data on a same-address write
  always_ff @(posedge clk) begin
    if (we_a) begin
      mem[addr_a] <= wdata_a;
    end
    if (we_b) begin
      mem[addr_b] <= wdata_b;
    end
    rdata_a <= mem[addr_a];
    rdata_b <= mem[addr_b];
  end

endmodule

`default_nettype wire

//--- logic/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  wire logic         clk,
  input  wire logic         arst_n,
  input  core_pkg::reg_addr_t rs1_addr,
  input  core_pkg::reg_addr_t rs2_addr,
  output core_pkg::word_t   rs1_data,
  output core_pkg::word_t   rs2_data,
  input  wire logic         we,
  input  core_pkg::reg_addr_t rd_addr,
  input  core_pkg::word_t   rd_data
);

  core_pkg::word_t regs [32];
  logic            wr_en;

  assign wr_en = we && (rd_addr != '0);  // x0 never written

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[rd_addr] <= rd_data;
    end
  end

  // Write-through so ID sees the value retiring this cycle
  assign rs1_data = (wr_en && rd_addr == rs1_addr) ? rd_data : regs[rs1_addr];
  assign rs2_data = (wr_en && rd_addr == rs2_addr) ? rd_data : regs[rs2_addr];

endmodule

`default_nettype wire

//--- logic/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  core_pkg::word_t     inst,
  input  wire logic           inst_valid,
  input  core_pkg::word_t     pc,
  input  core_pkg::word_t     rs1_data,
  input  core_pkg::word_t     rs2_data,
  input  core_pkg::ex_wb_t    ex_fwd,
  input  wire logic           ex_is_load,
  input  core_pkg::reg_addr_t wb_rd,
  input  wire logic           wb_we,
  input  core_pkg::word_t     wb_data,
  output core_pkg::reg_addr_t rs1_addr,
  output core_pkg::reg_addr_t rs2_addr,
  output core_pkg::id_ex_t    id_ex,
  output logic                redirect,
  output core_pkg::word_t     target,
  output logic                stall
);

  logic [6:0]         opcode;
  logic [2:0]         funct3;
  core_pkg::word_t    imm_i, imm_s, imm_b, imm_u, imm_j;
  core_pkg::word_t    imm;
  core_pkg::ex_ctrl_t ctrl;
  logic               legal, uses_rs1, uses_rs2;
  logic               is_branch, is_jal, is_jalr;
  logic               taken, active;
  core_pkg::word_t    op1, op2, jalr_sum;

  assign opcode   = inst[6:0];
  assign funct3   = inst[14:12];
  assign rs1_addr = inst[19:15];
  assign rs2_addr = inst[24:20];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    ctrl      = '0;
    imm       = '0;
    legal     = 1'b0;
    uses_rs1  = 1'b0;
    uses_rs2  = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_jalr   = 1'b0;
    case (opcode)
      core_pkg::OP_REG: begin
        legal          = 1'b1;
        uses_rs1       = 1'b1;
        uses_rs2       = 1'b1;
        ctrl.alu_func  = {inst[30], funct3};
        ctrl.reg_we    = 1'b1;
      end
      core_pkg::OP_IMM: begin
        legal          = 1'b1;
        uses_rs1       = 1'b1;
        imm            = imm_i;
        ctrl.alu_func  = {(funct3 == 3'b101) && inst[30], funct3};  // Only SRAI uses bit 30
        ctrl.alu_src_b = core_pkg::SRC_B_IMM;
        ctrl.reg_we    = 1'b1;
      end
      core_pkg::OP_LOAD: begin
        legal          = (funct3 == 3'b010);  // LW only
        uses_rs1       = 1'b1;
        imm            = imm_i;
        ctrl.alu_src_b = core_pkg::SRC_B_IMM;
        ctrl.reg_we    = 1'b1;
        ctrl.mem_rd    = 1'b1;
        ctrl.wb_sel    = core_pkg::WB_MEM;
      end
      core_pkg::OP_STORE: begin
        legal          = (funct3 == 3'b010);  // SW only
        uses_rs1       = 1'b1;
        uses_rs2       = 1'b1;
        imm            = imm_s;
        ctrl.alu_src_b = core_pkg::SRC_B_IMM;
        ctrl.mem_we    = 1'b1;
      end
      core_pkg::OP_BRANCH: begin
        legal     = (funct3[2:1] != 2'b01);
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b1;
        imm       = imm_b;
        is_branch = 1'b1;
      end
      core_pkg::OP_JAL: begin
        legal          = 1'b1;
        imm            = imm_j;
        ctrl.alu_src_a = core_pkg::SRC_A_PC;   // Link is pc + 4
        ctrl.alu_src_b = core_pkg::SRC_B_FOUR;
        ctrl.reg_we    = 1'b1;
        is_jal         = 1'b1;
      end
      core_pkg::OP_JALR: begin
        legal          = (funct3 == 3'b000);
        uses_rs1       = 1'b1;
        imm            = imm_i;
        ctrl.alu_src_a = core_pkg::SRC_A_PC;
        ctrl.alu_src_b = core_pkg::SRC_B_FOUR;
        ctrl.reg_we    = 1'b1;
        is_jalr        = 1'b1;
      end
      core_pkg::OP_LUI: begin
        legal          = 1'b1;
        imm            = imm_u;
        ctrl.alu_src_a = core_pkg::SRC_A_ZERO;
        ctrl.alu_src_b = core_pkg::SRC_B_IMM;
        ctrl.reg_we    = 1'b1;
      end
      core_pkg::OP_AUIPC: begin
        legal          = 1'b1;
        imm            = imm_u;
        ctrl.alu_src_a = core_pkg::SRC_A_PC;
        ctrl.alu_src_b = core_pkg::SRC_B_IMM;
        ctrl.reg_we    = 1'b1;
      end
      core_pkg::OP_SYSTEM: begin
        // CSRRW and CSRRWI to tohost with the old value going to rd
        legal        = (inst[31:20] == core_pkg::CSR_TOHOST) && (funct3[1:0] == 2'b01);
        uses_rs1     = !funct3[2];
        imm          = {27'b0, inst[19:15]};
        ctrl.csr_we  = 1'b1;
        ctrl.csr_imm = funct3[2];
        ctrl.reg_we  = 1'b1;
      end
      default: begin
      end
    endcase
    ctrl.rd = inst[11:7];
  end

  // EX first, then write-back, then the register file
  function automatic core_pkg::word_t fwd(core_pkg::reg_addr_t addr, core_pkg::word_t rf);
    core_pkg::word_t val;
    val = rf;
    if (addr != '0 && wb_we && wb_rd == addr) begin
      val = wb_data;
    end
    if (addr != '0 && ex_fwd.reg_we && ex_fwd.wb_sel == core_pkg::WB_ALU &&
        ex_fwd.rd == addr) begin
      val = ex_fwd.result;
    end
    return val;
  endfunction

  always_comb begin
    op1 = fwd(rs1_addr, rs1_data);
    op2 = fwd(rs2_addr, rs2_data);
  end

  // Load data is not ready until write-back
  assign stall = inst_valid && legal && ex_is_load && (ex_fwd.rd != '0) &&
                 ((uses_rs1 && rs1_addr == ex_fwd.rd) || (uses_rs2 && rs2_addr == ex_fwd.rd));
  assign active = inst_valid && legal && !stall;

  always_comb begin
    case (funct3)
      3'b000:  taken = (op1 == op2);
      3'b001:  taken = (op1 != op2);
      3'b100:  taken = ($signed(op1) < $signed(op2));
      3'b101:  taken = ($signed(op1) >= $signed(op2));
      3'b110:  taken = (op1 < op2);
      3'b111:  taken = (op1 >= op2);
      default: taken = 1'b0;
    endcase
  end

  assign jalr_sum = op1 + imm;
  assign target   = is_jalr ? {jalr_sum[31:1], 1'b0} : pc + imm;
  assign redirect = active && (is_jal || is_jalr || (is_branch && taken));

  assign id_ex.ctrl     = active ? ctrl : '0;  // Bubble otherwise
  assign id_ex.pc       = pc;
  assign id_ex.rs1_data = op1;
  assign id_ex.rs2_data = op2;
  assign id_ex.imm      = imm;

endmodule

`default_nettype wire

//--- logic/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  wire logic           clk,
  input  wire logic           arst_n,
  input  core_pkg::id_ex_t    id_ex,
  output core_pkg::word_t     alu_result,
  output core_pkg::dmem_addr_t dmem_addr,
  output logic                dmem_we,
  output core_pkg::word_t     dmem_wdata,
  output core_pkg::word_t     csr,
  output logic                csr_we,
  output logic                is_load
);

  core_pkg::word_t op_a, op_b, alu_out;
  logic [4:0]      shamt;

  always_comb begin
    case (id_ex.ctrl.alu_src_a)
      core_pkg::SRC_A_PC:   op_a = id_ex.pc;
      core_pkg::SRC_A_ZERO: op_a = '0;
      default:              op_a = id_ex.rs1_data;
    endcase
    case (id_ex.ctrl.alu_src_b)
      core_pkg::SRC_B_IMM:  op_b = id_ex.imm;
      core_pkg::SRC_B_FOUR: op_b = 32'd4;
      default:              op_b = id_ex.rs2_data;
    endcase
  end

  assign shamt = op_b[4:0];

  always_comb begin
    case (id_ex.ctrl.alu_func)
      core_pkg::ALU_SUB:  alu_out = op_a - op_b;
      core_pkg::ALU_SLL:  alu_out = op_a << shamt;
      core_pkg::ALU_SLT:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
      core_pkg::ALU_SLTU: alu_out = {31'b0, op_a < op_b};
      core_pkg::ALU_XOR:  alu_out = op_a ^ op_b;
      core_pkg::ALU_SRL:  alu_out = op_a >> shamt;
      core_pkg::ALU_SRA:  alu_out = core_pkg::word_t'($signed(op_a) >>> shamt);
      core_pkg::ALU_OR:   alu_out = op_a | op_b;
      core_pkg::ALU_AND:  alu_out = op_a & op_b;
      default:            alu_out = op_a + op_b;
    endcase
  end

  // CSR instructions return the old tohost value
  assign alu_result = id_ex.ctrl.csr_we ? csr : alu_out;

  assign dmem_addr  = alu_out[core_pkg::DMEM_AWIDTH+1:2];  // Word address
  assign dmem_we    = id_ex.ctrl.mem_we;
  assign dmem_wdata = id_ex.rs2_data;
  assign is_load    = id_ex.ctrl.mem_rd;

  // tohost register
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      csr    <= '0;
      csr_we <= 1'b0;
    end else begin
      csr_we <= id_ex.ctrl.csr_we;
      if (id_ex.ctrl.csr_we) begin
        csr <= id_ex.ctrl.csr_imm ? id_ex.imm : id_ex.rs1_data;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/riscv_core.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_core (
  input  wire logic            clk,
  input  wire logic            arst_n,
  input  wire logic            run,
  input  wire logic            load_we,
  input  core_pkg::imem_addr_t load_addr,
  input  core_pkg::word_t      load_data,
  output core_pkg::word_t      csr,
  output logic                 csr_we
);

  core_pkg::word_t      pc, if_pc, inst;
  logic                 if_valid;
  core_pkg::imem_addr_t fetch_addr;

  core_pkg::reg_addr_t  rs1_addr, rs2_addr;
  core_pkg::word_t      rs1_data, rs2_data;
  core_pkg::id_ex_t     id_ex_d, id_ex_q;
  core_pkg::ex_wb_t     ex_fwd, ex_wb_q;
  logic                 redirect, stall, ex_is_load;
  core_pkg::word_t      target;

  core_pkg::word_t      alu_result, dmem_wdata, dmem_rdata, wb_data;
  core_pkg::dmem_addr_t dmem_addr;
  logic                 dmem_we;

  // Fetch. A stall re-reads the instruction held in ID
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc       <= core_pkg::RESET_PC;
      if_valid <= 1'b0;
    end else if (!stall) begin
      if (redirect) begin
        pc       <= target;
        if_valid <= 1'b0;  // Kill the fall-through fetch
      end else if (run) begin
        pc       <= pc + 32'd4;
        if_valid <= 1'b1;
      end else begin
        if_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      if_pc <= pc;
    end
  end

  assign fetch_addr = stall ? if_pc[core_pkg::IMEM_AWIDTH+1:2]
                            : pc[core_pkg::IMEM_AWIDTH+1:2];

  sync_ram_dp #(
    .AWIDTH(core_pkg::IMEM_AWIDTH)
  ) i_imem (
    .clk    (clk),
    .we_a   (1'b0),
    .addr_a (fetch_addr),
    .wdata_a('0),
    .rdata_a(inst),
    .we_b   (load_we),    // Program load
    .addr_b (load_addr),
    .wdata_b(load_data),
    .rdata_b()
  );

  reg_file i_reg_file (
    .clk     (clk),
    .arst_n  (arst_n),
    .rs1_addr(rs1_addr),
    .rs2_addr(rs2_addr),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .we      (ex_wb_q.reg_we),
    .rd_addr (ex_wb_q.rd),
    .rd_data (wb_data)
  );

  decode_stage i_decode_stage (
    .inst      (inst),
    .inst_valid(if_valid),
    .pc        (if_pc),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .ex_fwd    (ex_fwd),
    .ex_is_load(ex_is_load),
    .wb_rd     (ex_wb_q.rd),
    .wb_we     (ex_wb_q.reg_we),
    .wb_data   (wb_data),
    .rs1_addr  (rs1_addr),
    .rs2_addr  (rs2_addr),
    .id_ex     (id_ex_d),
    .redirect  (redirect),
    .target    (target),
    .stall     (stall)
  );

  // Stall already turns id_ex_d into a bubble
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      id_ex_q <= '0;
    end else begin
      id_ex_q <= id_ex_d;
    end
  end

  execute_stage i_execute_stage (
    .clk       (clk),
    .arst_n    (arst_n),
    .id_ex     (id_ex_q),
    .alu_result(alu_result),
    .dmem_addr (dmem_addr),
    .dmem_we   (dmem_we),
    .dmem_wdata(dmem_wdata),
    .csr       (csr),
    .csr_we    (csr_we),
    .is_load   (ex_is_load)
  );

  sync_ram_dp #(
    .AWIDTH(core_pkg::DMEM_AWIDTH)
  ) i_dmem (
    .clk    (clk),
    .we_a   (dmem_we),
    .addr_a (dmem_addr),
    .wdata_a(dmem_wdata),
    .rdata_a(dmem_rdata),
    .we_b   (1'b0),
    .addr_b ('0),
    .wdata_b('0),
    .rdata_b()
  );

  assign ex_fwd.reg_we = id_ex_q.ctrl.reg_we;
  assign ex_fwd.rd     = id_ex_q.ctrl.rd;
  assign ex_fwd.wb_sel = id_ex_q.ctrl.wb_sel;
  assign ex_fwd.result = alu_result;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_wb_q <= '0;
    end else begin
      ex_wb_q <= ex_fwd;
    end
  end

  // Load data arrives from the RAM in this cycle
  assign wb_data = (ex_wb_q.wb_sel == core_pkg::WB_MEM) ? dmem_rdata : ex_wb_q.result;

endmodule

`default_nettype wire

//--- verification/riscv_core_props.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_core_props (
  input wire logic clk,
  input wire logic arst_n,
  input wire logic csr_we,
  input wire logic redirect,
  input wire logic if_valid
);

  // No tohost write in reset or in the two cycles after release
  csr_we_quiet_after_reset: assert property (@(posedge clk)
    !(arst_n && $past(arst_n) && $past(arst_n, 2)) |-> !csr_we)
    else $error("csr_we high during reset or within two cycles of release");

  csr_we_known: assert property (@(posedge clk) arst_n |-> !$isunknown(csr_we))
    else $error("csr_we unknown out of reset");

  // Fall-through fetch behind a taken branch or jump is killed
  redirect_kills_fetch: assert property (@(posedge clk) disable iff (!arst_n)
    redirect |=> !if_valid)
    else $error("valid instruction in ID right after a redirect");

endmodule

bind riscv_core riscv_core_props i_riscv_core_props (
  .clk     (clk),
  .arst_n  (arst_n),
  .csr_we  (csr_we),
  .redirect(redirect),
  .if_valid(if_valid)
);

`default_nettype wire

//--- verification/riscv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_core_tb;

  logic                 clk;
  logic                 arst_n;
  logic                 run;
  logic                 load_we;
  core_pkg::imem_addr_t load_addr;
  core_pkg::word_t      load_data;
  core_pkg::word_t      csr;
  logic                 csr_we;

  core_pkg::word_t stim [256];     // Raw words from the hex file
  core_pkg::word_t expected [$];   // tohost values in order
  int unsigned     n_inst;
  int unsigned     n_exp;
  int unsigned     seen;           // tohost writes matched so far
  bit              loaded;

  riscv_core i_riscv_core (
    .clk      (clk),
    .arst_n   (arst_n),
    .run      (run),
    .load_we  (load_we),
    .load_addr(load_addr),
    .load_data(load_data),
    .csr      (csr),
    .csr_we   (csr_we)
  );

  always #2 clk = ~clk;  // 4 ns period

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Done: errors found");
    $fatal(1, "testbench stopped");
  endtask

  // Word layout is a count, the instructions, a count and the expected tohost values
  task automatic read_program();
    $readmemh("verification/program_input.hex", stim);
    n_inst = stim[0];
    if (n_inst == 0 || n_inst > 200) begin
      abort_run($sformatf("Program file gives a bad instruction count of %0d", n_inst));
    end
    n_exp = stim[8'(n_inst + 1)];
    if (n_exp == 0 || n_inst + n_exp + 2 > 256) begin
      abort_run($sformatf("Program file gives a bad expected value count of %0d", n_exp));
    end
    for (int k = 0; k < int'(n_exp); k++) begin
      expected.push_back(stim[8'(n_inst + 2 + k)]);
    end
  endtask

  task automatic load_word(input core_pkg::imem_addr_t addr, input core_pkg::word_t data);
    @(posedge clk);
    #0.5;
    load_we   = 1'b1;
    load_addr = addr;
    load_data = data;
  endtask

  task automatic check_tohost(input int unsigned index);
    assert (csr === expected[index]) else begin
      abort_run($sformatf("Error at %0t: tohost write %0d is %h, expected %h",
                          $time, index, csr, expected[index]));
    end
  endtask

  initial begin
    clk       = 1'b0;
    arst_n    = 1'b0;
    run       = 1'b0;
    load_we   = 1'b0;
    load_addr = '0;
    load_data = '0;
    seen      = 0;
    loaded    = 1'b0;
    read_program();

    repeat (2) @(posedge clk);
    #0.5;
    arst_n = 1'b1;

    // Program goes in while fetch is held
    for (int k = 0; k < int'(n_inst); k++) begin
      load_word(core_pkg::imem_addr_t'(k), stim[8'(k + 1)]);
    end
    @(posedge clk);
    #0.5;
    load_we = 1'b0;
    run     = 1'b1;
    loaded  = 1'b1;

    // Outputs settle after the rising edge
    while (seen < n_exp) begin
      @(negedge clk);
      if (csr_we) begin
        check_tohost(seen);
        seen++;
      end
    end

    // Program now spins on its self-jump
    repeat (20) begin
      @(negedge clk);
      assert (!csr_we) else begin
        abort_run($sformatf("Error at %0t: extra tohost write of %h after the last value",
                            $time, csr));
      end
    end

    $display("Done: no errors");
    $finish;
  end

  initial begin : watchdog
    wait (loaded);
    repeat (8 * n_inst + 100) @(posedge clk);
    abort_run($sformatf("Timeout at %0t: only %0d of %0d tohost writes arrived",
                        $time, seen, n_exp));
  end

endmodule

`default_nettype wire

//--- verilog.f
logic/core_pkg.sv
logic/sync_ram_dp.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/riscv_core.sv
verification/riscv_core_props.sv
verification/riscv_core_tb.sv

//--- run.sh
#!/bin/sh
# Builds the riscv_core testbench with Verilator and runs it
# Exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module riscv_core_tb \
  --Mdir obj_dir -o riscv_core_sim \
  -f verilog.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/riscv_core_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

exit 0

//--- verification/program_input.hex
// Word 0 is the instruction count, then one instruction per line with its address
// and assembly, then the count of expected tohost values and the values in order
00000038 // instruction count
FFB00093 // 00 addi  x1, x0, -5
00300113 // 04 addi  x2, x0, 3
002081B3 // 08 add   x3, x1, x2
51E19073 // 0C csrrw x0, tohost, x3
40110233 // 10 sub   x4, x2, x1
51E21073 // 14 csrrw x0, tohost, x4
0020A2B3 // 18 slt   x5, x1, x2
0020B333 // 1C sltu  x6, x1, x2
4020D3B3 // 20 sra   x7, x1, x2
0020D433 // 24 srl   x8, x1, x2
51E29073 // 28 csrrw x0, tohost, x5
51E31073 // 2C csrrw x0, tohost, x6
51E39073 // 30 csrrw x0, tohost, x7
51E41073 // 34 csrrw x0, tohost, x8
00411493 // 38 slli  x9, x2, 4
FFF4C513 // 3C xori  x10, x9, -1
40255593 // 40 srai  x11, x10, 2
51E59073 // 44 csrrw x0, tohost, x11
FFF13613 // 48 sltiu x12, x2, -1
FFA0A693 // 4C slti  x13, x1, -6
0F057713 // 50 andi  x14, x10, 0xF0
00C707B3 // 54 add   x15, x14, x12
00D787B3 // 58 add   x15, x15, x13
51E79073 // 5C csrrw x0, tohost, x15
123458B7 // 60 lui   x17, 0x12345
67888893 // 64 addi  x17, x17, 0x678
05102023 // 68 sw    x17, 64(x0)
04002903 // 6C lw    x18, 64(x0)
51E91073 // 70 csrrw x0, tohost, x18
00001A17 // 74 auipc x20, 1
51EA1073 // 78 csrrw x0, tohost, x20
00700013 // 7C addi  x0, x0, 7
51E01073 // 80 csrrw x0, tohost, x0
51EFD073 // 84 csrrwi x0, tohost, 31
51EADAF3 // 88 csrrwi x21, tohost, 21
51EA9073 // 8C csrrw x0, tohost, x21
00208463 // 90 beq   x1, x2, +8
51E0D073 // 94 csrrwi x0, tohost, 1
00209463 // 98 bne   x1, x2, +8
51EFD073 // 9C csrrwi x0, tohost, 31
0020C463 // A0 blt   x1, x2, +8
51EFD073 // A4 csrrwi x0, tohost, 31
0020E463 // A8 bltu  x1, x2, +8
51E15073 // AC csrrwi x0, tohost, 2
0020D463 // B0 bge   x1, x2, +8
51E1D073 // B4 csrrwi x0, tohost, 3
0020F463 // B8 bgeu  x1, x2, +8
51EFD073 // BC csrrwi x0, tohost, 31
00800BEF // C0 jal   x23, +8
51EFD073 // C4 csrrwi x0, tohost, 31
51EB9073 // C8 csrrw x0, tohost, x23
0D900C13 // CC addi  x24, x0, 0xD9
000C0CE7 // D0 jalr  x25, 0(x24)
51EFD073 // D4 csrrwi x0, tohost, 31
51EC9073 // D8 csrrw x0, tohost, x25
0000006F // DC jal   x0, 0
00000013 // expected value count
FFFFFFFE // -5 + 3
00000008 // 3 - (-5)
00000001 // slt
00000000 // sltu
FFFFFFFF // sra
1FFFFFFF // srl
FFFFFFF3 // ~(3 << 4) >>> 2
000000C1 // 0xC0 + 1 + 0
12345678 // stored and loaded word
00001074 // auipc at 0x74
00000000 // x0 after a write
0000001F // csrrwi 31
00000015 // csrrwi 21
0000001F // old tohost returned in x21
00000001 // beq not taken
00000002 // bltu not taken
00000003 // bge not taken
000000C4 // jal link
000000D4 // jalr link
